// ==== hw/csiProtoPkg.sv ====
// CSI-2 protocol constants: data type codes, sync byte, long packet boundary
package csiProtoPkg;

	// ------------------------------
	// Data type codes
	// ------------------------------
	typedef enum logic [5:0]
	{
		dtFrameStart = 6'h00,	// Short, frame start
		dtFrameEnd   = 6'h01,	// Short, frame end
		dtLineStart  = 6'h02,	// Short, line start
		dtLineEnd    = 6'h03,	// Short, line end
		dtYuv422b8   = 6'h1E,	// Long, YUV422 8 bit
		dtRgb565     = 6'h22,	// Long, RGB565
		dtRaw8       = 6'h2A,	// Long, RAW8
		dtRaw10      = 6'h2B	// Long, RAW10
	} tCsiDataType;

	// ------------------------------
	// Link level constants
	// ------------------------------

	// HS leader byte seen by the PHY on each lane at SoT
	localparam logic [7:0] cSyncByte = 8'hB8;

	// Codes 0x00..0x0F are short packets
	// Everything at or above this carries a payload
	localparam logic [5:0] cLongPktMin = 6'h10;

endpackage

// ==== hw/csiRxPkg.sv ====
// Receiver internal types: merged word, FIFO entry, decoder states
package csiRxPkg;

	// ------------------------------
	// Datapath words
	// ------------------------------
	localparam int cWordBits = 16;	// Two lanes x one byte

	// Lane 0 byte in [7:0], lane 1 byte in [15:8]
	typedef logic [cWordBits-1:0] tCsiWord;

	// One FIFO slot
	typedef struct packed
	{
		logic    start;	// First word of a burst (sync cycle)
		tCsiWord word;
	} tFifoEntry;

	// ------------------------------
	// Packet decoder FSM
	// ------------------------------
	typedef enum logic [1:0]
	{
		stIdle,		// Waiting for a start word
		stHeadLow,	// DT/VC + word count LSB
		stHeadHigh,	// Word count MSB + ECC
		stPayload	// Long packet data
	} tDecState;

endpackage

// ==== hw/csiLaneMerge.sv ====
// Two-lane byte merge: lane registers, sync detect, SoT error discard, FIFO write
`timescale 1ns/1ps

module csiLaneMerge
	import csiRxPkg::*;
(
	input  logic       iSCLK,
	input  logic       qnHsRst,
	// PHY side, lanes assumed aligned
	input  logic [7:0] laneData0,
	input  logic [7:0] laneData1,
	input  logic       laneValid,	// From lane 1
	input  logic       laneSync,	// From lane 1
	input  logic       errSotSync,
	// FIFO write side
	output tFifoEntry  wrEntry,
	output logic       wrEn
);

	// ------------------------------
	// Accept and discard decision
	// ------------------------------
	logic    laneAccept;	// Sync cycle counts as data too
	logic    dropNow;
	logic    rDiscard;		// Burst after a bad SoT
	logic    rStart;
	logic    rWrEn;
	tCsiWord rWord;

	assign laneAccept = laneValid | laneSync;

	// A fresh sync decides for itself, otherwise follow the burst state
	assign dropNow = laneSync ? errSotSync : rDiscard;

	always_ff @(posedge iSCLK or negedge qnHsRst)
	begin
		if (!qnHsRst)
		begin
			rDiscard <= 1'b0;
			rStart   <= 1'b0;
			rWrEn    <= 1'b0;
		end
		else
		begin
			if (laneSync)
				rDiscard <= errSotSync;	// Held until next clean sync
			rStart <= laneSync;
			rWrEn  <= laneAccept & ~dropNow;
		end
	end

	// Byte pair, lane 1 on top
	always_ff @(posedge iSCLK)
	begin
		if (laneAccept)
			rWord <= {laneData1, laneData0};
	end

	assign wrEntry = '{start: rStart, word: rWord};
	assign wrEn    = rWrEn;

	// ------------------------------
	// Checks
	// ------------------------------

	// No write without a lane cycle behind it
	aWrFromLane: assert property (@(posedge iSCLK) disable iff (!qnHsRst)
		wrEn |-> $past(laneValid || laneSync))
		else $error("csiLaneMerge: wrEn without accepted lane cycle");

endmodule

// ==== hw/csiWordFifo.sv ====
// Synchronous word FIFO with start flag, full/empty and sticky overflow
`timescale 1ns/1ps

module csiWordFifo
	import csiRxPkg::*;
#(
	parameter int pFifoDepth = 64	// Power of two
)
(
	input  logic      iSCLK,
	input  logic      qnHsRst,
	// Write side
	input  tFifoEntry wrEntry,
	input  logic      wrEn,
	output logic      fifoFull,
	// Read side
	input  logic      rdEn,
	output tFifoEntry rdEntry,
	output logic      rdValid,
	output logic      fifoEmpty,
	output logic      overflow	// Sticky until reset
);

	localparam int cAddrBits = $clog2(pFifoDepth);
	localparam logic [cAddrBits:0] cFullCount = (cAddrBits+1)'(pFifoDepth);

	// ------------------------------
	// Storage and pointers
	// ------------------------------
	tFifoEntry            mem [pFifoDepth];
	logic [cAddrBits:0]   rWrPtr;		// Extra MSB for wrap
	logic [cAddrBits:0]   rRdPtr;
	logic [cAddrBits:0]   fillCount;
	logic                 wrOk;
	logic                 rdOk;
	logic                 rRdValid;
	logic                 rOverflow;

	assign fillCount = rWrPtr - rRdPtr;	// Wraps cleanly
	assign fifoFull  = (fillCount == cFullCount);
	assign fifoEmpty = (fillCount == '0);

	assign wrOk = wrEn & ~fifoFull;		// Dropped when full
	assign rdOk = rdEn & ~fifoEmpty;

	always_ff @(posedge iSCLK or negedge qnHsRst)
	begin
		if (!qnHsRst)
		begin
			rWrPtr    <= '0;
			rRdPtr    <= '0;
			rRdValid  <= 1'b0;
			rOverflow <= 1'b0;
		end
		else
		begin
			if (wrOk)
				rWrPtr <= rWrPtr + 1'b1;
			if (rdOk)
				rRdPtr <= rRdPtr + 1'b1;
			rRdValid <= rdOk;	// Data one cycle after rdEn
			if (wrEn && fifoFull)
				rOverflow <= 1'b1;
		end
	end

	// Memory and read register, no reset
	always_ff @(posedge iSCLK)
	begin
		if (wrOk)
			mem[rWrPtr[cAddrBits-1:0]] <= wrEntry;
		if (rdOk)
			rdEntry <= mem[rRdPtr[cAddrBits-1:0]];
	end

	assign rdValid  = rRdValid;
	assign overflow = rOverflow;

	// ------------------------------
	// Checks
	// ------------------------------

	// Decoder must honour empty
	aNoRdEmpty: assert property (@(posedge iSCLK) disable iff (!qnHsRst)
		!(rdEn && fifoEmpty))
		else $error("csiWordFifo: read while empty");

	// Pointer distance stays in range
	aFillRange: assert property (@(posedge iSCLK) disable iff (!qnHsRst)
		fillCount <= cFullCount)
		else $error("csiWordFifo: fill count %0d above depth", fillCount);

endmodule

// ==== hw/csiPacketDecoder.sv ====
// CSI-2 packet decoder: header parse FSM, payload counter, pixel and header outputs
`timescale 1ns/1ps

module csiPacketDecoder
	import csiProtoPkg::*, csiRxPkg::*;
(
	input  logic        iSCLK,
	input  logic        qnHsRst,
	// FIFO read side
	input  logic        fifoEmpty,
	output logic        rdEn,
	input  tFifoEntry   rdEntry,
	input  logic        rdValid,
	// Pixel path
	input  logic        pixelReady,
	output tCsiWord     pixel,
	output logic        pixelValid,
	// Header path has no ready
	output tCsiDataType dataType,
	output logic [1:0]  virtualChan,
	output logic [15:0] wordCount,
	output logic [7:0]  ecc,
	output logic        headerValid
);

	// ------------------------------
	// FIFO read control
	// ------------------------------
	assign rdEn = ~fifoEmpty & pixelReady;	// Stall under back-pressure

	// ------------------------------
	// Header decode helpers
	// ------------------------------
	tDecState    rState;
	tCsiWord     rHeadLow;		// First header word held until second
	logic [15:0] rWordsLeft;	// Payload words still due
	logic        rPixelValid;
	logic        rHeaderValid;
	logic [15:0] wcNext;		// Full word count at stHeadHigh
	logic [15:0] halfWords;		// Bytes / 2 rounded up
	logic        isLong;
	logic        headDone;		// Second header word returned
	logic        payWord;		// Payload word returned

	assign wcNext    = {rdEntry.word[7:0], rHeadLow[15:8]};
	assign halfWords = {1'b0, wcNext[15:1]} + {15'd0, wcNext[0]};
	assign isLong    = (rHeadLow[5:0] >= cLongPktMin);

	assign headDone = rdValid & ~rdEntry.start & (rState == stHeadHigh);
	assign payWord  = rdValid & ~rdEntry.start & (rState == stPayload);

	// ------------------------------
	// State machine
	// ------------------------------
	always_ff @(posedge iSCLK or negedge qnHsRst)
	begin
		if (!qnHsRst)
		begin
			rState       <= stIdle;
			rWordsLeft   <= '0;
			rPixelValid  <= 1'b0;
			rHeaderValid <= 1'b0;
		end
		else
		begin
			rPixelValid  <= payWord;
			rHeaderValid <= headDone;
			if (rdValid)
			begin
				if (rdEntry.start)
					rState <= stHeadLow;		// Sync word restarts parse
				else
				begin
					case (rState)
						stIdle:
							rState <= stIdle;	// Stray word dropped
						stHeadLow:
							rState <= stHeadHigh;
						stHeadHigh:
						begin
							rWordsLeft <= halfWords;
							// Short packet or empty long packet ends here
							if (isLong && (halfWords != '0))
								rState <= stPayload;
							else
								rState <= stIdle;
						end
						stPayload:
						begin
							rWordsLeft <= rWordsLeft - 1'b1;
							if (rWordsLeft == 16'd1)
								rState <= stIdle;	// Last word
						end
						default:
							rState <= stIdle;
					endcase
				end
			end
		end
	end

	// ------------------------------
	// Header and pixel registers
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (rdValid && (rState == stHeadLow) && !rdEntry.start)
			rHeadLow <= rdEntry.word;
		// All header fields change together
		if (headDone)
		begin
			dataType    <= tCsiDataType'(rHeadLow[5:0]);
			virtualChan <= rHeadLow[7:6];
			wordCount   <= wcNext;
			ecc         <= rdEntry.word[15:8];	// Reported only
		end
		if (payWord)
			pixel <= rdEntry.word;
	end

	assign pixelValid  = rPixelValid;
	assign headerValid = rHeaderValid;

	// ------------------------------
	// Checks
	// ------------------------------
	aStateLegal: assert property (@(posedge iSCLK) disable iff (!qnHsRst)
		!$isunknown(rState) && (rState inside {stIdle, stHeadLow, stHeadHigh, stPayload}))
		else $error("csiPacketDecoder: illegal state");

endmodule

// ==== hw/csiRxTop.sv ====
// CSI-2 two-lane receive top: lane merge, word FIFO, packet decoder
`timescale 1ns/1ps

module csiRxTop
	import csiProtoPkg::*, csiRxPkg::*;
#(
	parameter int pFifoDepth = 64
)
(
	input  logic        iSCLK,
	input  logic        qnHsRst,
	// D-PHY HS bytes
	input  logic [7:0]  laneData0,
	input  logic [7:0]  laneData1,
	input  logic        laneValid,
	input  logic        laneSync,
	input  logic        errSotSync,
	// Pixel out
	input  logic        pixelReady,
	output tCsiWord     pixel,
	output logic        pixelValid,
	// Header out
	output tCsiDataType dataType,
	output logic [1:0]  virtualChan,
	output logic [15:0] wordCount,
	output logic [7:0]  ecc,
	output logic        headerValid,
	// Status
	output logic        fifoFull,
	output logic        overflow
);

	// ------------------------------
	// Internal links
	// ------------------------------
	tFifoEntry wrEntry;		// Merge -> FIFO
	logic      wrEn;
	tFifoEntry rdEntry;		// FIFO -> decoder
	logic      rdEn;
	logic      rdValid;
	logic      fifoEmpty;

	csiLaneMerge uMerge
	(
		.iSCLK      (iSCLK),
		.qnHsRst    (qnHsRst),
		.laneData0  (laneData0),
		.laneData1  (laneData1),
		.laneValid  (laneValid),
		.laneSync   (laneSync),
		.errSotSync (errSotSync),
		.wrEntry    (wrEntry),
		.wrEn       (wrEn)
	);

	csiWordFifo #(.pFifoDepth(pFifoDepth)) uFifo
	(
		.iSCLK     (iSCLK),
		.qnHsRst   (qnHsRst),
		.wrEntry   (wrEntry),
		.wrEn      (wrEn),
		.fifoFull  (fifoFull),
		.rdEn      (rdEn),
		.rdEntry   (rdEntry),
		.rdValid   (rdValid),
		.fifoEmpty (fifoEmpty),
		.overflow  (overflow)
	);

	csiPacketDecoder uDecoder
	(
		.iSCLK       (iSCLK),
		.qnHsRst     (qnHsRst),
		.fifoEmpty   (fifoEmpty),
		.rdEn        (rdEn),
		.rdEntry     (rdEntry),
		.rdValid     (rdValid),
		.pixelReady  (pixelReady),
		.pixel       (pixel),
		.pixelValid  (pixelValid),
		.dataType    (dataType),
		.virtualChan (virtualChan),
		.wordCount   (wordCount),
		.ecc         (ecc),
		.headerValid (headerValid)
	);

endmodule

// ==== tb/tbClkGen.sv ====
// Testbench clock source and power-on reset
`timescale 1ns/1ps

module tbClkGen
#(
	parameter int pHalfNs    = 10,	// 20 ns period
	parameter int pRstCycles = 3
)
(
	output logic iSCLK,
	output logic qnHsRst
);

	initial
	begin
		iSCLK = 1'b0;
		forever #(pHalfNs) iSCLK = ~iSCLK;
	end

	// Reset held low, released on an edge
	initial
	begin
		qnHsRst = 1'b0;
		repeat (pRstCycles) @(posedge iSCLK);
		qnHsRst <= 1'b1;
	end

endmodule

// ==== tb/tbCsiRx.sv ====
// CSI-2 receiver testbench: random packets, reference queues, compare tasks, report
`timescale 1ns/1ps

module tbCsiRx
	import csiProtoPkg::*, csiRxPkg::*;
();

	localparam int cDrainLimit = 2000;	// Cycles per drain wait
	localparam int cResetLimit = 50;
	localparam int cFlagLimit  = 20;

	logic iSCLK, qnHsRst;
	logic [7:0] laneData0, laneData1;
	logic laneValid, laneSync, errSotSync;
	logic pixelReady = 1'b0;		// Only the ready process drives it
	tCsiWord pixel;
	logic pixelValid, headerValid, fifoFull, overflow;
	tCsiDataType dataType;
	logic [1:0] virtualChan;
	logic [15:0] wordCount;
	logic [7:0] ecc;

	int seed = 32'hc8a4;			// Packet stimulus
	int readySeed = 32'hc8a4 ^ 32'h0f0f;	// Ready toggling
	logic [31:0] readyBits;
	logic readyRandom = 1'b0;
	logic readyLevel = 1'b0;
	int hdrErrors = 0;
	int pixErrors = 0;
	int miscErrors = 0;

	// Reference queues, filled by the stimulus
	tCsiDataType expDt[$];
	logic [1:0]  expVc[$];
	logic [15:0] expWc[$];
	logic [7:0]  expEcc[$];
	tCsiWord     expPix[$];

	tCsiDataType shortTypes[4] = '{dtFrameStart, dtFrameEnd, dtLineStart, dtLineEnd};
	tCsiDataType longTypes[4]  = '{dtYuv422b8, dtRgb565, dtRaw8, dtRaw10};

	tbClkGen uClk (.iSCLK(iSCLK), .qnHsRst(qnHsRst));

	csiRxTop #(.pFifoDepth(16)) DUT
	(
		.iSCLK(iSCLK), .qnHsRst(qnHsRst),
		.laneData0(laneData0), .laneData1(laneData1),
		.laneValid(laneValid), .laneSync(laneSync), .errSotSync(errSotSync),
		.pixelReady(pixelReady), .pixel(pixel), .pixelValid(pixelValid),
		.dataType(dataType), .virtualChan(virtualChan), .wordCount(wordCount),
		.ecc(ecc), .headerValid(headerValid),
		.fifoFull(fifoFull), .overflow(overflow)
	);

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic checkHeader(input tCsiDataType expT, input logic [1:0] expV,
		input logic [15:0] expW, input logic [7:0] expE);
		begin
			if (dataType !== expT)
			begin
				$display("Mismatch at %0t: dataType expected %h, got %h", $time, expT, dataType);
				hdrErrors++;
			end
			if (virtualChan !== expV)
			begin
				$display("Mismatch at %0t: virtualChan expected %h, got %h", $time, expV,
					virtualChan);
				hdrErrors++;
			end
			if (wordCount !== expW)
			begin
				$display("Mismatch at %0t: wordCount expected %h, got %h", $time, expW, wordCount);
				hdrErrors++;
			end
			if (ecc !== expE)
			begin
				$display("Mismatch at %0t: ecc expected %h, got %h", $time, expE, ecc);
				hdrErrors++;
			end
		end
	endtask

	task automatic checkPixel(input tCsiWord expP);
		begin
			if (pixel !== expP)
			begin
				$display("Mismatch at %0t: pixel expected %h, got %h", $time, expP, pixel);
				pixErrors++;
			end
		end
	endtask

	task automatic checkFlag(input string name, input logic expF, input logic actF);
		begin
			if (actF !== expF)
			begin
				$display("Mismatch at %0t: %s expected %b, got %b", $time, name, expF, actF);
				miscErrors++;
			end
		end
	endtask

	task automatic reportAndStop;
		begin
			$display("Header errors: %0d, pixel errors: %0d, other errors: %0d",
				hdrErrors, pixErrors, miscErrors);
			if ((hdrErrors + pixErrors + miscErrors) == 0)
				$display("*** TEST PASSED ***");
			else
				$display("*** TEST FAILED ***");
			$finish;
		end
	endtask

	// Outputs sampled mid-cycle, away from the edge
	always @(negedge iSCLK)
	begin
		if (qnHsRst === 1'b1 && headerValid === 1'b1)
		begin
			if (expDt.size() == 0)
			begin
				$display("Unexpected header at %0t, none was sent", $time);
				hdrErrors++;
			end
			else
				checkHeader(expDt.pop_front(), expVc.pop_front(), expWc.pop_front(),
					expEcc.pop_front());
		end
		if (qnHsRst === 1'b1 && pixelValid === 1'b1)
		begin
			if (expPix.size() == 0)
			begin
				$display("Unexpected pixel at %0t, no payload pending", $time);
				pixErrors++;
			end
			else
				checkPixel(expPix.pop_front());
		end
	end

	// Downstream ready, fixed or random per cycle
	always @(posedge iSCLK)
	begin
		readyBits = $random(readySeed);
		pixelReady <= readyRandom ? readyBits[0] : readyLevel;
	end

	// ------------------------------
	// Lane drivers
	// ------------------------------
	task automatic sendWord(input logic [7:0] d0, input logic [7:0] d1,
		input logic sync, input logic err);
		begin
			@(posedge iSCLK);
			laneData0  <= d0;
			laneData1  <= d1;
			laneSync   <= sync;
			laneValid  <= !sync;	// Sync cycle accepted on its own
			errSotSync <= err;
		end
	endtask

	task automatic idleCycles(input int n);
		begin
			repeat (n)
			begin
				@(posedge iSCLK);
				laneValid  <= 1'b0;
				laneSync   <= 1'b0;
				errSotSync <= 1'b0;
			end
		end
	endtask

	// Sync, two header words, payload, idle gap
	task automatic sendPacket(input tCsiDataType dt, input logic [1:0] vc,
		input logic [15:0] wc, input logic [7:0] eccByte, input bit sotErr);
		int nWords;
		logic [31:0] rnd;
		tCsiWord w;
		begin
			nWords = (dt >= cLongPktMin) ? int'(wc[15:1]) : 0;
			if (!sotErr)
			begin
				expDt.push_back(dt);
				expVc.push_back(vc);
				expWc.push_back(wc);
				expEcc.push_back(eccByte);
			end
			sendWord(cSyncByte, cSyncByte, 1'b1, sotErr);
			sendWord({vc, dt}, wc[7:0], 1'b0, 1'b0);	// DT/VC, WC low
			sendWord(wc[15:8], eccByte, 1'b0, 1'b0);	// WC high, ECC
			for (int i = 0; i < nWords; i++)
			begin
				rnd = $random(seed);
				w   = rnd[15:0];
				if (!sotErr)
					expPix.push_back(w);
				sendWord(w[7:0], w[15:8], 1'b0, 1'b0);	// Lane 0 low byte
			end
			rnd = $random(seed);
			idleCycles(1 + int'(rnd[1:0]));
		end
	endtask

	task automatic randomPacket(input bit wantLong, input int maxBytes, input bit sotErr);
		logic [31:0] rnd;
		tCsiDataType dt;
		logic [15:0] wc;
		begin
			rnd = $random(seed);
			if (wantLong)
			begin
				dt = longTypes[rnd[1:0]];
				wc = 16'(2 * (1 + ({$random(seed)} % (maxBytes / 2))));	// Even, 2..max
			end
			else
			begin
				dt = shortTypes[rnd[1:0]];
				wc = rnd[31:16];	// Short packet data field
			end
			sendPacket(dt, rnd[5:4], wc, rnd[15:8], sotErr);
		end
	endtask

	// ------------------------------
	// Wait loops, each bounded
	// ------------------------------
	task automatic waitDrain;
		int cycles;
		begin
			cycles = 0;
			while ((expDt.size() != 0 || expPix.size() != 0) && cycles < cDrainLimit)
			begin
				@(posedge iSCLK);
				cycles++;
			end
			if (expDt.size() != 0 || expPix.size() != 0)
			begin
				$display("Timeout at %0t: expected header or pixel output never arrived", $time);
				miscErrors++;
				reportAndStop();
			end
		end
	endtask

	task automatic waitStatus(input bit wantOverflow);
		int cycles;
		begin
			cycles = 0;
			while (((wantOverflow ? overflow : fifoFull) !== 1'b1) && cycles < cFlagLimit)
			begin
				@(negedge iSCLK);
				cycles++;
			end
			if ((wantOverflow ? overflow : fifoFull) !== 1'b1)
			begin
				$display("Timeout at %0t: %s never went high", $time,
					wantOverflow ? "overflow" : "fifoFull");
				miscErrors++;
				reportAndStop();
			end
		end
	endtask

	task automatic waitReset;
		int cycles;
		begin
			cycles = 0;
			while (qnHsRst !== 1'b1 && cycles < cResetLimit)
			begin
				@(posedge iSCLK);
				cycles++;
			end
			if (qnHsRst !== 1'b1)
			begin
				$display("Timeout at %0t: reset was never released", $time);
				miscErrors++;
				reportAndStop();
			end
		end
	endtask

	// Back-pressured burst, 17 words into a 16 deep FIFO
	task automatic fillFifo;
		logic [31:0] rnd;
		begin
			for (int n = 1; n <= 17; n++)
			begin
				rnd = $random(seed);
				if (n == 1)
					sendWord(cSyncByte, cSyncByte, 1'b1, 1'b0);
				else if (n == 2)
					sendWord({2'd0, dtRaw8}, 8'd32, 1'b0, 1'b0);
				else if (n == 3)
					sendWord(8'd0, rnd[7:0], 1'b0, 1'b0);
				else
					sendWord(rnd[7:0], rnd[15:8], 1'b0, 1'b0);
				if (n >= 15)
				begin
					idleCycles(2);
					@(negedge iSCLK);
				end
				if (n == 15)
					checkFlag("fifoFull", 1'b0, fifoFull);
				if (n == 16)
				begin
					waitStatus(1'b0);
					checkFlag("overflow", 1'b0, overflow);	// Full, nothing lost yet
				end
				if (n == 17)
					waitStatus(1'b1);
			end
		end
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial
	begin
		laneData0  <= 8'd0;
		laneData1  <= 8'd0;
		laneValid  <= 1'b0;
		laneSync   <= 1'b0;
		errSotSync <= 1'b0;
		waitReset();
		idleCycles(2);
		@(negedge iSCLK);
		checkFlag("pixelValid", 1'b0, pixelValid);	// Quiet after reset
		checkFlag("headerValid", 1'b0, headerValid);
		checkFlag("fifoFull", 1'b0, fifoFull);
		checkFlag("overflow", 1'b0, overflow);

		readyLevel <= 1'b1;
		for (int i = 0; i < 8; i++)	// Short packets
		begin
			randomPacket(1'b0, 0, 1'b0);
			waitDrain();
		end
		for (int i = 0; i < 10; i++)	// Long packets, full payload range
		begin
			randomPacket(1'b1, 32, 1'b0);
			waitDrain();
		end

		readyRandom <= 1'b1;		// At most 15 words per packet
		for (int i = 0; i < 20; i++)
		begin
			randomPacket(i[0], 24, 1'b0);
			waitDrain();
		end
		readyRandom <= 1'b0;
		@(negedge iSCLK);
		checkFlag("overflow", 1'b0, overflow);

		randomPacket(1'b1, 32, 1'b1);	// Bad SoT, burst dropped
		idleCycles(8);
		randomPacket(1'b1, 32, 1'b0);
		waitDrain();

		readyLevel <= 1'b0;
		idleCycles(3);
		fillFifo();
		reportAndStop();
	end

endmodule

// ==== verilog.f ====
hw/csiProtoPkg.sv
hw/csiRxPkg.sv
hw/csiLaneMerge.sv
hw/csiWordFifo.sv
hw/csiPacketDecoder.sv
hw/csiRxTop.sv
tb/tbClkGen.sv
tb/tbCsiRx.sv

// ==== Makefile ====
# Verilator build for the CSI-2 two-lane receiver

VERILATOR ?= verilator
TOP       ?= tbCsiRx
SEED      ?= 1
BUILD_DIR ?= obj_dir
FILELIST  ?= verilog.f

BIN       := $(BUILD_DIR)/V$(TOP)
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

sim: $(BIN)
	@out="$$(./$(BIN) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
